// ==== verilog/rvv_defines.svh ====
`ifndef RVV_DEFINES_SVH
`define RVV_DEFINES_SVH

// Lanes per vector register
`define RVV_LANES 4

// Width of one lane in bits
`define RVV_LANE_W 16

// Vector register file size
`define RVV_NUM_VREG 8

// Command queue entries
`define RVV_CQ_DEPTH 4

// Scalar write-back buffer entries
`define RVV_RT_DEPTH 2

// vl holds 0 up to RVV_LANES
`define RVV_VL_W 3

`endif

// ==== verilog/rvv_pkg.sv ====
`include "rvv_defines.svh"

package rvv_pkg;

  typedef enum logic [2:0] {
    SETVL   = 3'd0,
    VMV_VX  = 3'd1,
    VADD_VV = 3'd2,
    VSUB_VV = 3'd3,
    VAND_VV = 3'd4,
    VXOR_VV = 3'd5,
    VREDSUM = 3'd6
  } rvv_op_e;

  // Configuration layout, only the destination scalar register
  typedef struct packed {
    rvv_op_e     op;
    logic [4:0]  rd;
    logic [23:0] unused;
  } rvv_cfg_inst_t;

  // Vector layout, register fields follow the opcode
  typedef struct packed {
    rvv_op_e                             op;
    logic [$clog2(`RVV_NUM_VREG)-1:0]    vd;
    logic [$clog2(`RVV_NUM_VREG)-1:0]    vs1;
    logic [$clog2(`RVV_NUM_VREG)-1:0]    vs2;
    logic [4:0]                          rd;
    logic [31-8-3*$clog2(`RVV_NUM_VREG):0] pad;
  } rvv_alu_inst_t;

  typedef union packed {
    rvv_cfg_inst_t cfg;
    rvv_alu_inst_t alu;
  } rvv_inst_u;

  // One decoded vector command, vl captured at issue
  typedef struct packed {
    rvv_op_e                          op;
    logic [$clog2(`RVV_NUM_VREG)-1:0] vd;
    logic [$clog2(`RVV_NUM_VREG)-1:0] vs1;
    logic [$clog2(`RVV_NUM_VREG)-1:0] vs2;
    logic [4:0]                       rd;
    logic [`RVV_LANE_W-1:0]           scalar;
    logic [`RVV_VL_W-1:0]             vl;
  } rvv_cmd_t;

endpackage

// ==== verilog/rvv_frontend.sv ====
`include "rvv_defines.svh"

module rvv_frontend (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               inst_valid_i,
  input  rvv_pkg::rvv_inst_u                 inst_data_i,
  input  logic [31:0]                        reg_read_data_i,
  output logic                               inst_ready_o,
  output logic                               reg_write_valid_o,
  output logic [4:0]                         reg_write_addr_o,
  output logic [31:0]                        reg_write_data_o,
  output logic [`RVV_VL_W-1:0]               config_state_o,
  output logic                               cmd_valid_o,
  output rvv_pkg::rvv_cmd_t                  cmd_data_o,
  input  logic [$clog2(`RVV_CQ_DEPTH+1)-1:0] remaining_i
);

  localparam int CNT_W = $clog2(`RVV_CQ_DEPTH + 1);
  localparam logic [`RVV_VL_W-1:0] VL_MAX = `RVV_LANES;

  logic                 accept;
  logic                 is_cfg;
  logic [CNT_W-1:0]     held;
  logic [`RVV_VL_W-1:0] vl_q;
  logic [`RVV_VL_W-1:0] vl_new;

  // Credit check, the output register may still owe the queue one slot
  always_comb begin
    held    = '0;
    held[0] = cmd_valid_o;
  end

  assign inst_ready_o   = remaining_i > held;
  assign accept         = inst_valid_i && inst_ready_o;
  assign is_cfg         = inst_data_i.cfg.op == rvv_pkg::SETVL;
  assign vl_new         = (reg_read_data_i > `RVV_LANES) ? VL_MAX
                                                         : reg_read_data_i[`RVV_VL_W-1:0];
  assign config_state_o = vl_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vl_q              <= VL_MAX;
      reg_write_valid_o <= 1'b0;
      cmd_valid_o       <= 1'b0;
    end else begin
      reg_write_valid_o <= accept && is_cfg;
      cmd_valid_o       <= accept && !is_cfg;
      if (accept && is_cfg) begin
        vl_q <= vl_new;
      end
    end
  end

  // Write-back and command payload
  always_ff @(posedge clk_i) begin
    if (accept && is_cfg) begin
      reg_write_addr_o <= inst_data_i.cfg.rd;
      reg_write_data_o <= {{(32-`RVV_VL_W){1'b0}}, vl_new};
    end
    if (accept && !is_cfg) begin
      cmd_data_o.op     <= inst_data_i.alu.op;
      cmd_data_o.vd     <= inst_data_i.alu.vd;
      cmd_data_o.vs1    <= inst_data_i.alu.vs1;
      cmd_data_o.vs2    <= inst_data_i.alu.vs2;
      cmd_data_o.rd     <= inst_data_i.alu.rd;
      cmd_data_o.scalar <= reg_read_data_i[`RVV_LANE_W-1:0];
      // Stamped with vl as seen at acceptance
      cmd_data_o.vl     <= vl_q;
    end
  end

  // Queue must have had room when this command was accepted
  a_push_has_credit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_o |-> remaining_i != '0
  );

endmodule

// ==== verilog/rvv_cmd_queue.sv ====
`include "rvv_defines.svh"

module rvv_cmd_queue (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               push_i,
  input  rvv_pkg::rvv_cmd_t                  push_data_i,
  input  logic                               pop_i,
  output logic                               valid_o,
  output rvv_pkg::rvv_cmd_t                  data_o,
  output logic [$clog2(`RVV_CQ_DEPTH+1)-1:0] remaining_o
);

  localparam int DEPTH = `RVV_CQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  rvv_pkg::rvv_cmd_t mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;

  assign valid_o     = count_q != '0;
  assign data_o      = mem_q[rd_ptr_q];
  assign remaining_o = CNT_W'(DEPTH) - count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) push_i |-> count_q != CNT_W'(DEPTH)
  );

  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pop_i |-> count_q != '0
  );

endmodule

// ==== verilog/rvv_backend.sv ====
`include "rvv_defines.svh"

module rvv_backend (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              cq_valid_i,
  input  rvv_pkg::rvv_cmd_t cq_data_i,
  output logic              cq_pop_o,
  input  logic              rt_full_i,
  output logic              rt_push_o,
  output logic [4:0]        rt_addr_o,
  output logic [31:0]       rt_data_o,
  output logic              busy_o
);

  logic [`RVV_LANES-1:0][`RVV_LANE_W-1:0] vrf_q [`RVV_NUM_VREG];
  logic [`RVV_LANES-1:0][`RVV_LANE_W-1:0] wr_lanes;
  logic [31:0]                            red_sum;
  logic                                   is_red;

  assign is_red = cq_data_i.op == rvv_pkg::VREDSUM;

  // Reductions wait for a free retire slot
  assign cq_pop_o  = cq_valid_i && (!is_red || !rt_full_i);
  assign rt_push_o = cq_pop_o && is_red;
  assign rt_addr_o = cq_data_i.rd;
  assign rt_data_o = red_sum;
  assign busy_o    = cq_valid_i;

  // Lane ALU computes vd = vs2 op vs1
  always_comb begin
    logic [`RVV_LANE_W-1:0] a;
    logic [`RVV_LANE_W-1:0] b;
    logic [`RVV_LANE_W-1:0] res;
    red_sum = '0;
    for (int i = 0; i < `RVV_LANES; i++) begin
      a = vrf_q[cq_data_i.vs1][i];
      b = vrf_q[cq_data_i.vs2][i];
      case (cq_data_i.op)
        rvv_pkg::VMV_VX:  res = cq_data_i.scalar;
        rvv_pkg::VADD_VV: res = b + a;
        rvv_pkg::VSUB_VV: res = b - a;
        rvv_pkg::VAND_VV: res = b & a;
        rvv_pkg::VXOR_VV: res = b ^ a;
        default:          res = vrf_q[cq_data_i.vd][i];
      endcase
      // Tail lanes keep their old value
      wr_lanes[i] = (i < cq_data_i.vl) ? res : vrf_q[cq_data_i.vd][i];
      if (i < cq_data_i.vl) begin
        red_sum = red_sum + {{(32-`RVV_LANE_W){1'b0}}, b};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `RVV_NUM_VREG; r++) begin
        vrf_q[r] <= '0;
      end
    end else if (cq_pop_o && !is_red) begin
      vrf_q[cq_data_i.vd] <= wr_lanes;
    end
  end

  // A reduction stalled on a full retire buffer keeps its place at the queue head
  a_red_stall_holds: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cq_valid_i && is_red && rt_full_i |=> cq_valid_i && $stable(cq_data_i)
  );

endmodule

// ==== verilog/rvv_retire.sv ====
`include "rvv_defines.svh"

module rvv_retire (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        push_i,
  input  logic [4:0]  addr_i,
  input  logic [31:0] data_i,
  output logic        full_o,
  output logic        empty_o,
  output logic        async_rd_valid_o,
  output logic [4:0]  async_rd_addr_o,
  output logic [31:0] async_rd_data_o,
  input  logic        async_rd_ready_i
);

  localparam int DEPTH = `RVV_RT_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  logic [4:0]       addr_q [DEPTH];
  logic [31:0]      data_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  assign full_o           = count_q == CNT_W'(DEPTH);
  assign empty_o          = count_q == '0;
  assign async_rd_valid_o = !empty_o;
  // Head entry stays put until the handshake completes
  assign async_rd_addr_o  = addr_q[rd_ptr_q];
  assign async_rd_data_o  = data_q[rd_ptr_q];
  assign pop              = async_rd_valid_o && async_rd_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_q[wr_ptr_q] <= addr_i;
      data_q[wr_ptr_q] <= data_i;
    end
  end

  a_rd_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    async_rd_valid_o && !async_rd_ready_i |=>
      async_rd_valid_o && $stable(async_rd_addr_o) && $stable(async_rd_data_o)
  );

endmodule

// ==== verilog/rvv_core.sv ====
`include "rvv_defines.svh"

module rvv_core (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 inst_valid_i,
  input  rvv_pkg::rvv_inst_u   inst_data_i,
  input  logic [31:0]          reg_read_data_i,
  output logic                 inst_ready_o,
  output logic                 reg_write_valid_o,
  output logic [4:0]           reg_write_addr_o,
  output logic [31:0]          reg_write_data_o,
  output logic [`RVV_VL_W-1:0] config_state_o,
  output logic                 async_rd_valid_o,
  output logic [4:0]           async_rd_addr_o,
  output logic [31:0]          async_rd_data_o,
  input  logic                 async_rd_ready_i,
  output logic                 rvv_idle_o
);

  logic                               fe_cmd_valid;
  rvv_pkg::rvv_cmd_t                  fe_cmd_data;
  logic [$clog2(`RVV_CQ_DEPTH+1)-1:0] cq_remaining;
  logic                               cq_valid;
  rvv_pkg::rvv_cmd_t                  cq_data;
  logic                               cq_pop;
  logic                               rt_full;
  logic                               rt_empty;
  logic                               rt_push;
  logic [4:0]                         rt_addr;
  logic [31:0]                        rt_data;
  logic                               be_busy;

  rvv_frontend u_frontend (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .inst_valid_i      (inst_valid_i),
    .inst_data_i       (inst_data_i),
    .reg_read_data_i   (reg_read_data_i),
    .inst_ready_o      (inst_ready_o),
    .reg_write_valid_o (reg_write_valid_o),
    .reg_write_addr_o  (reg_write_addr_o),
    .reg_write_data_o  (reg_write_data_o),
    .config_state_o    (config_state_o),
    .cmd_valid_o       (fe_cmd_valid),
    .cmd_data_o        (fe_cmd_data),
    .remaining_i       (cq_remaining)
  );

  rvv_cmd_queue u_cmd_queue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (fe_cmd_valid),
    .push_data_i (fe_cmd_data),
    .pop_i       (cq_pop),
    .valid_o     (cq_valid),
    .data_o      (cq_data),
    .remaining_o (cq_remaining)
  );

  rvv_backend u_backend (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cq_valid_i (cq_valid),
    .cq_data_i  (cq_data),
    .cq_pop_o   (cq_pop),
    .rt_full_i  (rt_full),
    .rt_push_o  (rt_push),
    .rt_addr_o  (rt_addr),
    .rt_data_o  (rt_data),
    .busy_o     (be_busy)
  );

  rvv_retire u_retire (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .push_i           (rt_push),
    .addr_i           (rt_addr),
    .data_i           (rt_data),
    .full_o           (rt_full),
    .empty_o          (rt_empty),
    .async_rd_valid_o (async_rd_valid_o),
    .async_rd_addr_o  (async_rd_addr_o),
    .async_rd_data_o  (async_rd_data_o),
    .async_rd_ready_i (async_rd_ready_i)
  );

  // Nothing in flight anywhere in the pipe
  assign rvv_idle_o = !fe_cmd_valid && !be_busy && rt_empty;

endmodule

// ==== test/rvv_ref.svh ====
`ifndef RVV_REF_SVH
`define RVV_REF_SVH

// Model state, advanced in program order when an instruction is accepted
logic [`RVV_LANE_W-1:0] m_vrf [`RVV_NUM_VREG][`RVV_LANES];
int unsigned            m_vl;

function automatic void model_reset();
  for (int r = 0; r < `RVV_NUM_VREG; r++) begin
    for (int l = 0; l < `RVV_LANES; l++) begin
      m_vrf[r][l] = '0;
    end
  end
  m_vl = `RVV_LANES;
endfunction

// Returns the scalar result of SETVL or VREDSUM, zero for other ops
function automatic logic [31:0] model_apply(rvv_pkg::rvv_inst_u inst, logic [31:0] opnd);
  logic [31:0]            result;
  logic [`RVV_LANE_W-1:0] a;
  logic [`RVV_LANE_W-1:0] b;
  result = '0;
  if (inst.cfg.op == rvv_pkg::SETVL) begin
    m_vl = (opnd < `RVV_LANES) ? opnd : `RVV_LANES;
    return m_vl;
  end
  // Only lanes below vl are touched
  for (int unsigned l = 0; l < m_vl; l++) begin
    a = m_vrf[inst.alu.vs1][l];
    b = m_vrf[inst.alu.vs2][l];
    case (inst.alu.op)
      rvv_pkg::VMV_VX:  m_vrf[inst.alu.vd][l] = opnd[`RVV_LANE_W-1:0];
      rvv_pkg::VADD_VV: m_vrf[inst.alu.vd][l] = b + a;
      rvv_pkg::VSUB_VV: m_vrf[inst.alu.vd][l] = b - a;
      rvv_pkg::VAND_VV: m_vrf[inst.alu.vd][l] = b & a;
      rvv_pkg::VXOR_VV: m_vrf[inst.alu.vd][l] = b ^ a;
      rvv_pkg::VREDSUM: result = result + 32'(b);
      default:          result = result;
    endcase
  end
  return result;
endfunction

`endif

// ==== test/rvv_tb.sv ====
`include "rvv_defines.svh"

module rvv_tb;

  localparam int TIMEOUT = 2000;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 inst_valid_i;
  rvv_pkg::rvv_inst_u   inst_data_i;
  logic [31:0]          reg_read_data_i;
  logic                 inst_ready_o;
  logic                 reg_write_valid_o;
  logic [4:0]           reg_write_addr_o;
  logic [31:0]          reg_write_data_o;
  logic [`RVV_VL_W-1:0] config_state_o;
  logic                 async_rd_valid_o;
  logic [4:0]           async_rd_addr_o;
  logic [31:0]          async_rd_data_o;
  logic                 async_rd_ready_i;
  logic                 rvv_idle_o;

  int          ready_mode;
  int          cyc;
  int          stall_seen;
  int          exp_cfg_cyc [$];
  logic [4:0]  exp_cfg_addr [$];
  logic [31:0] exp_cfg_data [$];
  logic [4:0]  exp_rd_addr [$];
  logic [31:0] exp_rd_data [$];

  `include "rvv_ref.svh"

  rvv_core dut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // Write-back ready pattern chosen per phase
  always @(posedge clk_i) begin
    #1;
    case (ready_mode)
      0:       async_rd_ready_i = 1'b1;
      1:       async_rd_ready_i = ($urandom_range(0, 1) == 1);
      default: async_rd_ready_i = ($urandom_range(0, 7) == 0);
    endcase
  end

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(string sig, logic [31:0] exp, logic [31:0] act);
    abort_run($sformatf("ERR t=%0t %s expected %h got %h", $time, sig, exp, act));
  endtask

  // Compare at the falling edge where outputs are stable
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (!inst_ready_o) stall_seen++;
      if (reg_write_valid_o) begin
        assert (exp_cfg_cyc.size() != 0) else abort_run("Register write-back with no SETVL");
        assert (exp_cfg_cyc[0] == cyc) else abort_run("Register write-back out of its cycle");
        assert (reg_write_addr_o == exp_cfg_addr[0])
          else report_mismatch("reg_write_addr_o", 32'(exp_cfg_addr[0]), 32'(reg_write_addr_o));
        assert (reg_write_data_o == exp_cfg_data[0])
          else report_mismatch("reg_write_data_o", exp_cfg_data[0], reg_write_data_o);
        assert (32'(config_state_o) == exp_cfg_data[0])
          else report_mismatch("config_state_o", exp_cfg_data[0], 32'(config_state_o));
        void'(exp_cfg_cyc.pop_front());
        void'(exp_cfg_addr.pop_front());
        void'(exp_cfg_data.pop_front());
      end else begin
        assert (exp_cfg_cyc.size() == 0 || exp_cfg_cyc[0] > cyc)
          else abort_run("Register write-back missing one cycle after SETVL");
      end
      if (async_rd_valid_o && async_rd_ready_i) begin
        assert (exp_rd_data.size() != 0) else abort_run("Scalar write-back with no VREDSUM");
        assert (async_rd_addr_o == exp_rd_addr[0])
          else report_mismatch("async_rd_addr_o", 32'(exp_rd_addr[0]), 32'(async_rd_addr_o));
        assert (async_rd_data_o == exp_rd_data[0])
          else report_mismatch("async_rd_data_o", exp_rd_data[0], async_rd_data_o);
        void'(exp_rd_addr.pop_front());
        void'(exp_rd_data.pop_front());
      end
    end
  end

  function automatic rvv_pkg::rvv_inst_u cfg_inst(logic [4:0] rd);
    rvv_pkg::rvv_inst_u inst;
    inst        = '0;
    inst.cfg.op = rvv_pkg::SETVL;
    inst.cfg.rd = rd;
    return inst;
  endfunction

  function automatic rvv_pkg::rvv_inst_u alu_inst(rvv_pkg::rvv_op_e op, logic [2:0] vd,
                                                  logic [2:0] vs1, logic [2:0] vs2,
                                                  logic [4:0] rd);
    rvv_pkg::rvv_inst_u inst;
    inst         = '0;
    inst.alu.op  = op;
    inst.alu.vd  = vd;
    inst.alu.vs1 = vs1;
    inst.alu.vs2 = vs2;
    inst.alu.rd  = rd;
    return inst;
  endfunction

  // Holds the instruction until accepted, then records what must come back
  task automatic send_inst(rvv_pkg::rvv_inst_u inst, logic [31:0] opnd);
    int          waited;
    logic [31:0] result;
    waited          = 0;
    inst_valid_i    = 1'b1;
    inst_data_i     = inst;
    reg_read_data_i = opnd;
    @(negedge clk_i);
    while (!inst_ready_o) begin
      waited++;
      if (waited > TIMEOUT) abort_run("Timeout waiting for inst_ready_o");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    inst_valid_i = 1'b0;
    result       = model_apply(inst, opnd);
    if (inst.cfg.op == rvv_pkg::SETVL) begin
      exp_cfg_cyc.push_back(cyc);
      exp_cfg_addr.push_back(inst.cfg.rd);
      exp_cfg_data.push_back(result);
    end else if (inst.alu.op == rvv_pkg::VREDSUM) begin
      exp_rd_addr.push_back(inst.alu.rd);
      exp_rd_data.push_back(result);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_cfg_cyc.size() != 0 || exp_rd_data.size() != 0 || !rvv_idle_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) abort_run("Timeout waiting for results and rvv_idle_o");
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    int unsigned        vl_ops [4];
    int unsigned        r;
    rvv_pkg::rvv_op_e   op;
    rvv_pkg::rvv_inst_u inst;
    vl_ops = '{0, 2, 4, 9};
    void'($urandom(32'h2ce0_deae));
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    inst_valid_i     = 1'b0;
    inst_data_i      = '0;
    reg_read_data_i  = '0;
    async_rd_ready_i = 1'b1;
    ready_mode       = 0;
    cyc              = 0;
    stall_seen       = 0;
    model_reset();
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    assert (inst_ready_o) else abort_run("inst_ready_o low after reset");
    assert (!async_rd_valid_o) else abort_run("async_rd_valid_o high after reset");
    assert (config_state_o == 3'd4) else report_mismatch("config_state_o", 4, 32'(config_state_o));
    @(posedge clk_i);
    #1;

    // SETVL clamping and a reduction of the cleared v0
    for (int i = 0; i < 4; i++) send_inst(cfg_inst(5'(i + 1)), vl_ops[i]);
    send_inst(alu_inst(rvv_pkg::VREDSUM, 3'd0, 3'd0, 3'd0, 5'd9), '0);

    // Each lane op checked through a reduction
    send_inst(alu_inst(rvv_pkg::VMV_VX, 3'd1, 3'd0, 3'd0, 5'd0), 32'h0001_1234);
    send_inst(alu_inst(rvv_pkg::VMV_VX, 3'd2, 3'd0, 3'd0, 5'd0), 32'h0000_0f0f);
    send_inst(alu_inst(rvv_pkg::VADD_VV, 3'd3, 3'd1, 3'd2, 5'd0), '0);
    send_inst(alu_inst(rvv_pkg::VREDSUM, 3'd0, 3'd0, 3'd3, 5'd10), '0);
    send_inst(alu_inst(rvv_pkg::VSUB_VV, 3'd4, 3'd2, 3'd1, 5'd0), '0);
    send_inst(alu_inst(rvv_pkg::VREDSUM, 3'd0, 3'd0, 3'd4, 5'd11), '0);
    send_inst(alu_inst(rvv_pkg::VAND_VV, 3'd5, 3'd1, 3'd2, 5'd0), '0);
    send_inst(alu_inst(rvv_pkg::VREDSUM, 3'd0, 3'd0, 3'd5, 5'd12), '0);
    send_inst(alu_inst(rvv_pkg::VXOR_VV, 3'd6, 3'd1, 3'd2, 5'd0), '0);
    send_inst(alu_inst(rvv_pkg::VREDSUM, 3'd0, 3'd0, 3'd6, 5'd13), '0);
    wait_drain();

    // Tail lanes above vl = 2 must survive
    send_inst(alu_inst(rvv_pkg::VMV_VX, 3'd7, 3'd0, 3'd0, 5'd0), 32'd5);
    send_inst(cfg_inst(5'd14), 32'd2);
    send_inst(alu_inst(rvv_pkg::VMV_VX, 3'd7, 3'd0, 3'd0, 5'd0), 32'd9);
    send_inst(cfg_inst(5'd15), 32'd4);
    send_inst(alu_inst(rvv_pkg::VREDSUM, 3'd0, 3'd0, 3'd7, 5'd16), '0);
    wait_drain();

    // Reduction burst under random write-back ready
    ready_mode = 1;
    for (int i = 0; i < 12; i++) begin
      send_inst(alu_inst(rvv_pkg::VREDSUM, 3'd0, 3'd0, 3'($urandom), 5'($urandom)), '0);
    end
    wait_drain();

    // Mixed random stream with a slow write-back
    ready_mode = 2;
    stall_seen = 0;
    for (int i = 0; i < 200; i++) begin
      repeat ($urandom_range(0, 1)) begin
        @(posedge clk_i);
        #1;
      end
      r  = $urandom_range(0, 9);
      op = (r >= 6) ? rvv_pkg::VREDSUM : rvv_pkg::rvv_op_e'(3'(r));
      if (op == rvv_pkg::SETVL) begin
        send_inst(cfg_inst(5'($urandom)), 32'($urandom_range(0, 6)));
      end else begin
        inst = alu_inst(op, 3'($urandom), 3'($urandom), 3'($urandom), 5'($urandom));
        send_inst(inst, $urandom);
      end
    end
    wait_drain();
    assert (stall_seen > 0) else abort_run("inst_ready_o never dropped in the random stream");

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+verilog
+incdir+test
verilog/rvv_pkg.sv
verilog/rvv_frontend.sv
verilog/rvv_cmd_queue.sv
verilog/rvv_backend.sv
verilog/rvv_retire.sv
verilog/rvv_core.sv
test/rvv_tb.sv

// ==== Makefile ====
# Verilator build and run for the vector coprocessor testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f list.f --top-module rvv_tb -o sim

run: compile
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
